//--- files.f
hdl/axi_xbar_pkg.sv
hdl/axi_write_router.sv
hdl/axi_b_arbiter.sv
hdl/axi_write_xbar.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_axi_write_xbar.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f files.f --top-module tb_axi_write_xbar -o sim_axi_write_xbar \
  && ./obj_dir/sim_axi_write_xbar > sim.log 2>&1 \
  || echo "Build or run did not complete"

cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log 2>/dev/null && exit 0 || exit 1

//--- dv/tb_axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_xbar;

  localparam int NUM_TESTS = 7;
  localparam int WAIT_MAX  = 200;

  logic clk;
  logic rstn;

  axi_xbar_pkg::aw_req_t   m_aw;
  logic                    m_awvalid;
  logic                    m_awready;
  axi_xbar_pkg::w_beat_t   m_w;
  logic                    m_wvalid;
  logic                    m_wready;
  axi_xbar_pkg::b_resp_t   m_b;
  logic                    m_bvalid;
  logic                    m_bready;
  axi_xbar_pkg::aw_req_s_t s_aw;
  logic [2:0]              s_awvalid;
  logic [2:0]              s_awready;
  axi_xbar_pkg::w_beat_t   s_w;
  logic [2:0]              s_wvalid;
  logic [2:0]              s_wready;
  axi_xbar_pkg::b_resp_s_t s_b [3];
  logic [2:0]              s_bvalid;
  logic [2:0]              s_bready;

  // Stimulus table
  string      t_name  [NUM_TESTS];
  logic [3:0] t_id    [NUM_TESTS];
  logic [31:0] t_addr [NUM_TESTS];
  logic [7:0] t_len   [NUM_TESTS];
  int         t_slave [NUM_TESTS];
  logic [1:0] t_resp  [NUM_TESTS];
  int         t_stall [NUM_TESTS];

  // Slave model state
  logic [7:0] sl_id    [3];
  logic       sl_armed [3];
  int         sl_cnt   [3];
  integer     seed = 4678;

  int   issued   [3];
  int   returned [3];
  int   hold_cnt;
  logic timed_out;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .rstn (rstn)
  );

  axi_write_xbar dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_b       (m_b),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_w       (s_w),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_b       (s_b),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready)
  );

  tb_checker u_checker (
    .clk       (clk),
    .rstn      (rstn),
    .num_tests (NUM_TESTS),
    .m_aw      (m_aw),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_b       (m_b),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_w       (s_w),
    .s_wvalid  (s_wvalid),
    .s_bready  (s_bready)
  );

  function automatic int entry_of(input logic [3:0] id);
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (t_id[i] == id) begin
        return i;
      end
    end
    return 0;
  endfunction

  // Slaves accept AW and W, answer after 0 to 5 idle cycles
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s_bvalid  <= '0;
      s_wready  <= '0;
      s_awready <= '0;
      for (int k = 0; k < 3; k++) begin
        sl_id[k]    <= '0;
        sl_armed[k] <= 1'b0;
        sl_cnt[k]   <= 0;
        s_b[k]      <= '0;
      end
    end else begin
      for (int k = 0; k < 3; k++) begin
        s_awready[k] <= $random(seed) % 3 != 0;
        s_wready[k] <= $random(seed) % 4 != 0;
        if (s_awvalid[k] && s_awready[k]) begin
          sl_id[k] <= s_aw.id;
        end
        if (s_wvalid[k] && s_wready[k] && s_w.last) begin
          sl_armed[k] <= 1'b1;
          sl_cnt[k]   <= int'($unsigned($random(seed)) % 6);
        end else if (sl_armed[k] && !s_bvalid[k]) begin
          if (sl_cnt[k] == 0) begin
            s_bvalid[k]  <= 1'b1;
            s_b[k].id    <= sl_id[k];
            s_b[k].resp  <= t_resp[entry_of(sl_id[k][3:0])];
            sl_armed[k]  <= 1'b0;
          end else begin
            sl_cnt[k] <= sl_cnt[k] - 1;
          end
        end
        if (s_bvalid[k] && s_bready[k]) begin
          s_bvalid[k] <= 1'b0;
        end
      end
    end
  end

  // Master B side, holds bready low for the entry's stall count
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m_bready <= 1'b0;
      hold_cnt <= 0;
      for (int k = 0; k < 3; k++) begin
        returned[k] <= 0;
      end
    end else if (m_bvalid && m_bready) begin
      m_bready <= 1'b0;
      returned[t_slave[entry_of(m_b.id)]] <= returned[t_slave[entry_of(m_b.id)]] + 1;
    end else if (m_bvalid) begin
      if (hold_cnt >= t_stall[entry_of(m_b.id)]) begin
        m_bready <= 1'b1;
        hold_cnt <= 0;
      end else begin
        hold_cnt <= hold_cnt + 1;
      end
    end
  end

  task automatic set_entry(input int i, input string name, input logic [3:0] id,
                           input logic [31:0] addr, input logic [7:0] len, input int slave,
                           input logic [1:0] resp, input int stall);
    t_name[i]  = name;
    t_id[i]    = id;
    t_addr[i]  = addr;
    t_len[i]   = len;
    t_slave[i] = slave;
    t_resp[i]  = resp;
    t_stall[i] = stall;
  endtask

  task automatic send_aw(input int i, output logic ok);
    int n;
    @(posedge clk);
    m_aw      <= '{id: t_id[i], addr: t_addr[i], len: t_len[i]};
    m_awvalid <= 1'b1;
    ok = 1'b0;
    for (n = 0; n < WAIT_MAX && !ok; n++) begin
      @(negedge clk);
      ok = m_awready;
    end
    if (!ok) begin
      $display("Timeout: AW of %s was never accepted", t_name[i]);
    end
  endtask

  task automatic send_w(input int i, output logic ok);
    int n;
    ok = 1'b1;
    for (int b = 0; b <= int'(t_len[i]) && ok; b++) begin
      @(posedge clk);
      m_awvalid <= 1'b0;
      m_w       <= '{data: {8'(i), 8'h5a, 8'h00, 8'(b)}, strb: 4'hf, last: b == int'(t_len[i])};
      m_wvalid  <= 1'b1;
      ok = 1'b0;
      for (n = 0; n < WAIT_MAX && !ok; n++) begin
        @(negedge clk);
        ok = m_wready;
      end
      if (!ok) begin
        $display("Timeout: beat %0d of %s was never accepted", b, t_name[i]);
      end
    end
    @(posedge clk);
    m_wvalid <= 1'b0;
  endtask

  task automatic wait_slave_free(input int s, output logic ok);
    int n;
    ok = issued[s] == returned[s];
    for (n = 0; n < WAIT_MAX && !ok; n++) begin
      @(negedge clk);
      ok = issued[s] == returned[s];
    end
    if (!ok) begin
      $display("Timeout: slave %0d never returned its write response", s);
    end
  endtask

  initial begin
    logic ok;
    int   n;
    set_entry(0, "s0_single", 4'h1, 32'h0000_0100, 8'd0, 0, axi_xbar_pkg::AXI_RESP_OKAY, 0);
    set_entry(1, "s1_burst", 4'h2, 32'h1000_0040, 8'd3, 1, axi_xbar_pkg::AXI_RESP_OKAY, 0);
    set_entry(2, "s2_slverr", 4'h3, 32'h2000_0800, 8'd1, 2, axi_xbar_pkg::AXI_RESP_SLVERR, 0);
    set_entry(3, "s1_stall", 4'h4, 32'h1000_1000, 8'd2, 1, axi_xbar_pkg::AXI_RESP_OKAY, 3);
    set_entry(4, "conc_s0", 4'h5, 32'h0000_2000, 8'd1, 0, axi_xbar_pkg::AXI_RESP_OKAY, 1);
    set_entry(5, "conc_s1", 4'h6, 32'h1000_2000, 8'd0, 1, axi_xbar_pkg::AXI_RESP_SLVERR, 0);
    set_entry(6, "conc_s2", 4'h7, 32'h2000_3000, 8'd2, 2, axi_xbar_pkg::AXI_RESP_OKAY, 2);
    m_aw      = '0;
    m_awvalid = 1'b0;
    m_w       = '0;
    m_wvalid  = 1'b0;
    timed_out = 1'b0;
    for (int k = 0; k < 3; k++) begin
      issued[k] = 0;
    end

    ok = 1'b0;
    for (n = 0; n < WAIT_MAX && !ok; n++) begin
      @(negedge clk);
      ok = rstn;
    end
    if (!ok) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end

    for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
      wait_slave_free(t_slave[i], ok);
      if (ok) begin
        send_aw(i, ok);
      end
      if (ok) begin
        issued[t_slave[i]] = issued[t_slave[i]] + 1;
        send_w(i, ok);
      end
      timed_out = !ok;
    end

    for (int k = 0; k < 3 && !timed_out; k++) begin
      wait_slave_free(k, ok);
      timed_out = !ok;
    end
    repeat (4) @(negedge clk);

    u_checker.print_summary();
    if (!timed_out && u_checker.error_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input logic                    clk,
  input logic                    rstn,
  input int                      num_tests,
  input axi_xbar_pkg::aw_req_t   m_aw,
  input logic                    m_awvalid,
  input logic                    m_awready,
  input axi_xbar_pkg::w_beat_t   m_w,
  input logic                    m_wvalid,
  input logic                    m_wready,
  input axi_xbar_pkg::b_resp_t   m_b,
  input logic                    m_bvalid,
  input logic                    m_bready,
  input axi_xbar_pkg::aw_req_s_t s_aw,
  input logic [2:0]              s_awvalid,
  input axi_xbar_pkg::w_beat_t   s_w,
  input logic [2:0]              s_wvalid,
  input logic [2:0]              s_bready
);

  // Per-test state, indexed by the master ID
  logic        seen      [16];
  int          beats     [16];
  logic        done      [16];
  logic        bad       [16];
  string       bad_field [16];
  logic [63:0] bad_exp   [16];
  logic [63:0] bad_act   [16];

  logic [3:0]            w_id;
  logic                  holding;
  axi_xbar_pkg::b_resp_t held;
  logic                  rst_bad;
  logic                  rst_reported;
  int                    pass_cnt;
  int                    fail_cnt;

  function automatic int entry_of(input logic [3:0] id);
    for (int i = 0; i < num_tests; i++) begin
      if (tb_axi_write_xbar.t_id[i] == id) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Keeps the first mismatch of a test
  task automatic note(input logic [3:0] id, input string field, input logic [63:0] exp_v,
                      input logic [63:0] act_v);
    if (!bad[id]) begin
      bad[id]       = 1'b1;
      bad_field[id] = field;
      bad_exp[id]   = exp_v;
      bad_act[id]   = act_v;
    end
  endtask

  always @(negedge clk) begin : sample
    int                    e;
    logic [2:0]            exp_sel;
    logic                  idle_bad;
    logic [7:0]            exp_sid;
    axi_xbar_pkg::w_beat_t exp_w;
    idle_bad = m_awready | m_wready | m_bvalid | (|s_awvalid) | (|s_wvalid);
    if (!rstn) begin
      for (int i = 0; i < 16; i++) begin
        seen[i]  = 1'b0;
        beats[i] = 0;
        done[i]  = 1'b0;
        bad[i]   = 1'b0;
      end
      w_id         = '0;
      holding      = 1'b0;
      held         = '0;
      rst_bad      = rst_bad | idle_bad;
      rst_reported = 1'b0;
      pass_cnt     = 0;
      fail_cnt     = 0;
    end else begin
      if (!rst_reported) begin
        rst_reported = 1'b1;
        if (rst_bad || idle_bad) begin
          $display("FAIL reset_state expected 0 actual 1");
          fail_cnt++;
        end else begin
          $display("PASS reset_state");
          pass_cnt++;
        end
      end

      if (m_awvalid && m_awready) begin
        e = entry_of(m_aw.id);
        if (e < 0) begin
          $display("Address request carries an ID that no test uses");
          fail_cnt++;
        end else begin
          exp_sel = 3'b001 << tb_axi_write_xbar.t_slave[e];
          exp_sid = {axi_xbar_pkg::MASTER1_CODE, tb_axi_write_xbar.t_id[e]};
          if (s_awvalid != exp_sel) begin
            note(m_aw.id, "aw slave", 64'(exp_sel), 64'(s_awvalid));
          end
          if (s_aw.id != exp_sid) begin
            note(m_aw.id, "slave id", 64'(exp_sid), 64'(s_aw.id));
          end
          if (s_aw.addr != tb_axi_write_xbar.t_addr[e] ||
              s_aw.len != tb_axi_write_xbar.t_len[e]) begin
            note(m_aw.id, "aw payload", 64'(tb_axi_write_xbar.t_addr[e]), 64'(s_aw.addr));
          end
          seen[m_aw.id] = 1'b1;
          w_id          = m_aw.id;
        end
      end

      if (m_wvalid && m_wready) begin
        e = entry_of(w_id);
        if (e >= 0) begin
          exp_sel    = 3'b001 << tb_axi_write_xbar.t_slave[e];
          exp_w.data = {8'(e), 8'h5a, 8'h00, 8'(beats[w_id])};
          exp_w.strb = 4'hf;
          exp_w.last = beats[w_id] == int'(tb_axi_write_xbar.t_len[e]);
          if (s_wvalid != exp_sel) begin
            note(w_id, "w slave", 64'(exp_sel), 64'(s_wvalid));
          end
          if (s_w != exp_w) begin
            note(w_id, "w beat", 64'(exp_w), 64'(s_w));
          end
          beats[w_id]++;
        end
      end

      if (m_bvalid) begin
        e = entry_of(m_b.id);
        if (holding && m_b != held) begin
          note(held.id, "stalled b", 64'(held), 64'(m_b));
        end
        if (e < 0) begin
          $display("Write response carries an ID that no test uses");
          fail_cnt++;
        end else if (done[m_b.id]) begin
          $display("Test %s got a second write response", tb_axi_write_xbar.t_name[e]);
          fail_cnt++;
        end else if (!m_bready) begin
          if (s_bready != 3'b000) begin
            note(m_b.id, "slave bready", 64'd0, 64'(s_bready));
          end
        end else begin
          if (m_b.resp != tb_axi_write_xbar.t_resp[e]) begin
            note(m_b.id, "resp", 64'(tb_axi_write_xbar.t_resp[e]), 64'(m_b.resp));
          end
          if (!seen[m_b.id] || beats[m_b.id] != int'(tb_axi_write_xbar.t_len[e]) + 1) begin
            note(m_b.id, "beat count", 64'(tb_axi_write_xbar.t_len[e]) + 64'd1,
                 64'(beats[m_b.id]));
          end
          done[m_b.id] = 1'b1;
          if (bad[m_b.id]) begin
            $display("FAIL %s expected %0h actual %0h (%s)", tb_axi_write_xbar.t_name[e],
                     bad_exp[m_b.id], bad_act[m_b.id], bad_field[m_b.id]);
            fail_cnt++;
          end else begin
            $display("PASS %s", tb_axi_write_xbar.t_name[e]);
            pass_cnt++;
          end
        end
      end
      holding = m_bvalid && !m_bready;
      held    = m_b;
    end
  end

  initial begin
    rst_bad = 1'b0;
  end

  function automatic int missing_count();
    int n;
    n = 0;
    for (int i = 0; i < num_tests; i++) begin
      if (!done[tb_axi_write_xbar.t_id[i]]) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic int error_total();
    return fail_cnt + missing_count();
  endfunction

  task automatic print_summary();
    for (int i = 0; i < num_tests; i++) begin
      if (!done[tb_axi_write_xbar.t_id[i]]) begin
        $display("Test %s never got its write response", tb_axi_write_xbar.t_name[i]);
      end
    end
    $display("Tests: %0d passed, %0d failed", pass_cnt, error_total());
  endtask

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hdl/axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_xbar (
  input  logic                                    clk,
  input  logic                                    rstn,
  // Master 1
  input  axi_xbar_pkg::aw_req_t                   m_aw,
  input  logic                                    m_awvalid,
  output logic                                    m_awready,
  input  axi_xbar_pkg::w_beat_t                   m_w,
  input  logic                                    m_wvalid,
  output logic                                    m_wready,
  output axi_xbar_pkg::b_resp_t                   m_b,
  output logic                                    m_bvalid,
  input  logic                                    m_bready,
  // Slaves 0 to 2
  output axi_xbar_pkg::aw_req_s_t                 s_aw,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_awvalid,
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_awready,
  output axi_xbar_pkg::w_beat_t                   s_w,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_wvalid,
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_wready,
  input  axi_xbar_pkg::b_resp_s_t                 s_b [axi_xbar_pkg::AXI_NUM_SLAVES],
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_bvalid,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_bready
);

  logic wlast_done;

  axi_write_router u_router (
    .clk        (clk),
    .rstn       (rstn),
    .m_aw       (m_aw),
    .m_awvalid  (m_awvalid),
    .m_awready  (m_awready),
    .m_w        (m_w),
    .m_wvalid   (m_wvalid),
    .m_wready   (m_wready),
    .s_aw       (s_aw),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .s_w        (s_w),
    .s_wvalid   (s_wvalid),
    .s_wready   (s_wready),
    .wlast_done (wlast_done)
  );

  // Response path armed by the router's last-beat pulse
  axi_b_arbiter u_b_arb (
    .clk        (clk),
    .rstn       (rstn),
    .wlast_done (wlast_done),
    .s_b        (s_b),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready),
    .m_b        (m_b),
    .m_bvalid   (m_bvalid),
    .m_bready   (m_bready)
  );

endmodule

`default_nettype wire

//--- hdl/axi_b_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_b_arbiter (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  logic                                    wlast_done,
  // Slave responses
  input  axi_xbar_pkg::b_resp_s_t                 s_b [axi_xbar_pkg::AXI_NUM_SLAVES],
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_bvalid,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0] s_bready,
  // Master 1 response
  output axi_xbar_pkg::b_resp_t                   m_b,
  output logic                                    m_bvalid,
  input  logic                                    m_bready
);

  axi_xbar_pkg::data_arb_lock_t lock;
  axi_xbar_pkg::data_arb_lock_t lock_nxt;
  axi_xbar_pkg::slave_sel_t     grant;
  axi_xbar_pkg::b_resp_s_t      b_sel;
  axi_xbar_pkg::axi_master_id_t master;
  axi_xbar_pkg::pend_cnt_t      pend_cnt;
  axi_xbar_pkg::pend_cnt_t      pend_cnt_nxt;

  logic grant_vld;
  logic bvalid_sel;
  logic bready_m;
  logic b_hs;
  logic b_enable;

  function automatic axi_xbar_pkg::data_arb_lock_t held_lock(
    input axi_xbar_pkg::slave_sel_t sel
  );
    axi_xbar_pkg::data_arb_lock_t l;
    case (sel)
      axi_xbar_pkg::SEL_S1: l = axi_xbar_pkg::LOCK_S1;
      axi_xbar_pkg::SEL_S2: l = axi_xbar_pkg::LOCK_S2;
      default:              l = axi_xbar_pkg::LOCK_S0;
    endcase
    return l;
  endfunction

  // Locked slave, or lowest valid one when free
  always_comb begin
    grant_vld = 1'b1;
    grant     = axi_xbar_pkg::SEL_S0;
    case (lock)
      axi_xbar_pkg::LOCK_S0: grant = axi_xbar_pkg::SEL_S0;
      axi_xbar_pkg::LOCK_S1: grant = axi_xbar_pkg::SEL_S1;
      axi_xbar_pkg::LOCK_S2: grant = axi_xbar_pkg::SEL_S2;
      default: begin
        if (b_enable && s_bvalid[0]) begin
          grant = axi_xbar_pkg::SEL_S0;
        end else if (b_enable && s_bvalid[1]) begin
          grant = axi_xbar_pkg::SEL_S1;
        end else if (b_enable && s_bvalid[2]) begin
          grant = axi_xbar_pkg::SEL_S2;
        end else begin
          grant_vld = 1'b0;
        end
      end
    endcase
  end

  always_comb begin
    b_sel.id   = '0;
    b_sel.resp = axi_xbar_pkg::AXI_RESP_SLVERR;
    bvalid_sel = 1'b0;
    if (grant_vld) begin
      b_sel      = s_b[grant];
      bvalid_sel = s_bvalid[grant];
    end
  end

  // Ready only towards the granted slave
  always_comb begin
    s_bready = '0;
    if (grant_vld) begin
      s_bready[grant] = bready_m;
    end
  end

  assign master = axi_xbar_pkg::data_decoder(b_sel.id);

  // Only master 1 is present, others get idle values
  always_comb begin
    m_b.id   = '0;
    m_b.resp = axi_xbar_pkg::AXI_RESP_SLVERR;
    m_bvalid = 1'b0;
    bready_m = 1'b0;
    case (master)
      axi_xbar_pkg::AXI_MASTER_1_ID: begin
        m_b.id   = b_sel.id[axi_xbar_pkg::AXI_ID_BITS-1:0];
        m_b.resp = b_sel.resp;
        m_bvalid = bvalid_sel;
        bready_m = m_bready;
      end
      default: ;
    endcase
  end

  assign b_hs = bvalid_sel & bready_m;

  // Hold while stalled, rotate after acceptance
  always_comb begin
    lock_nxt = lock;
    if (bvalid_sel) begin
      if (b_hs) begin
        case (grant)
          axi_xbar_pkg::SEL_S0:
            lock_nxt = s_bvalid[1] ? axi_xbar_pkg::LOCK_S1 :
                       s_bvalid[2] ? axi_xbar_pkg::LOCK_S2 : axi_xbar_pkg::LOCK_NO;
          axi_xbar_pkg::SEL_S1:
            lock_nxt = s_bvalid[2] ? axi_xbar_pkg::LOCK_S2 :
                       s_bvalid[0] ? axi_xbar_pkg::LOCK_S0 : axi_xbar_pkg::LOCK_NO;
          default:
            lock_nxt = s_bvalid[0] ? axi_xbar_pkg::LOCK_S0 :
                       s_bvalid[1] ? axi_xbar_pkg::LOCK_S1 : axi_xbar_pkg::LOCK_NO;
        endcase
      end else begin
        lock_nxt = held_lock(grant);
      end
    end
  end

  // Writes whose response is still owed
  always_comb begin
    pend_cnt_nxt = pend_cnt;
    case ({wlast_done, b_hs})
      2'b10:   pend_cnt_nxt = pend_cnt + axi_xbar_pkg::pend_cnt_t'(1);
      2'b01:   pend_cnt_nxt = pend_cnt - axi_xbar_pkg::pend_cnt_t'(1);
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock     <= axi_xbar_pkg::LOCK_NO;
      pend_cnt <= '0;
      b_enable <= 1'b0;
    end else begin
      lock     <= lock_nxt;
      pend_cnt <= pend_cnt_nxt;
      // Opens on a finished data phase, drops with the last owed response
      b_enable <= (pend_cnt_nxt != '0);
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_write_router.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_router (
  input  logic                                          clk,
  input  logic                                          rstn,
  // Master 1 write address and data
  input  axi_xbar_pkg::aw_req_t                         m_aw,
  input  logic                                          m_awvalid,
  output logic                                          m_awready,
  input  axi_xbar_pkg::w_beat_t                         m_w,
  input  logic                                          m_wvalid,
  output logic                                          m_wready,
  // Slave side, payload shared by all slaves
  output axi_xbar_pkg::aw_req_s_t                       s_aw,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0]       s_awvalid,
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0]       s_awready,
  output axi_xbar_pkg::w_beat_t                         s_w,
  output logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0]       s_wvalid,
  input  logic [axi_xbar_pkg::AXI_NUM_SLAVES-1:0]       s_wready,
  // Last beat accepted by the target slave
  output logic                                          wlast_done
);

  axi_xbar_pkg::route_state_t state;
  axi_xbar_pkg::route_state_t state_nxt;
  axi_xbar_pkg::slave_sel_t   target;
  axi_xbar_pkg::slave_sel_t   aw_sel;

  logic [axi_xbar_pkg::SLAVE_SEL_BITS-1:0] region;
  logic                                    aw_hit;
  logic                                    aw_hs;
  logic                                    w_hs;

  assign region =
    m_aw.addr[axi_xbar_pkg::AXI_ADDR_BITS-1:axi_xbar_pkg::SLAVE_SEL_LSB];

  // Address decode
  always_comb begin
    aw_hit = 1'b1;
    aw_sel = axi_xbar_pkg::SEL_S0;
    case (region)
      axi_xbar_pkg::SLAVE0_REGION: aw_sel = axi_xbar_pkg::SEL_S0;
      axi_xbar_pkg::SLAVE1_REGION: aw_sel = axi_xbar_pkg::SEL_S1;
      axi_xbar_pkg::SLAVE2_REGION: aw_sel = axi_xbar_pkg::SEL_S2;
      // Unmapped, request never reaches a slave
      default: aw_hit = 1'b0;
    endcase
  end

  // Master code goes above the master's own ID
  always_comb begin
    s_aw.id   = {axi_xbar_pkg::MASTER1_CODE, m_aw.id};
    s_aw.addr = m_aw.addr;
    s_aw.len  = m_aw.len;
  end

  // AW only while no data phase is open
  always_comb begin
    s_awvalid = '0;
    m_awready = 1'b0;
    if (state == axi_xbar_pkg::ROUTE_IDLE && aw_hit) begin
      s_awvalid[aw_sel] = m_awvalid;
      m_awready         = s_awready[aw_sel];
    end
  end

  assign aw_hs = m_awvalid & m_awready;

  // W beats follow the registered target
  assign s_w = m_w;

  always_comb begin
    s_wvalid = '0;
    m_wready = 1'b0;
    if (state == axi_xbar_pkg::ROUTE_DATA) begin
      s_wvalid[target] = m_wvalid;
      m_wready         = s_wready[target];
    end
  end

  assign w_hs       = m_wvalid & m_wready;
  assign wlast_done = w_hs & m_w.last;

  always_comb begin
    state_nxt = state;
    case (state)
      axi_xbar_pkg::ROUTE_IDLE: begin
        if (aw_hs) begin
          state_nxt = axi_xbar_pkg::ROUTE_DATA;
        end
      end
      axi_xbar_pkg::ROUTE_DATA: begin
        if (wlast_done) begin
          state_nxt = axi_xbar_pkg::ROUTE_IDLE;
        end
      end
      default: state_nxt = axi_xbar_pkg::ROUTE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= axi_xbar_pkg::ROUTE_IDLE;
      target <= axi_xbar_pkg::SEL_S0;
    end else begin
      state <= state_nxt;
      if (aw_hs) begin
        target <= aw_sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

  // Bus widths
  localparam int AXI_ID_BITS    = 4;
  localparam int AXI_IDS_BITS   = 8;
  localparam int AXI_ADDR_BITS  = 32;
  localparam int AXI_DATA_BITS  = 32;
  localparam int AXI_STRB_BITS  = AXI_DATA_BITS / 8;
  localparam int AXI_LEN_BITS   = 8;
  localparam int AXI_RESP_BITS  = 2;
  localparam int AXI_NUM_SLAVES = 3;

  localparam logic [AXI_RESP_BITS-1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [AXI_RESP_BITS-1:0] AXI_RESP_SLVERR = 2'b10;

  // Slave select field at the top of the address
  localparam int SLAVE_SEL_LSB  = 28;
  localparam int SLAVE_SEL_BITS = AXI_ADDR_BITS - SLAVE_SEL_LSB;

  localparam logic [SLAVE_SEL_BITS-1:0] SLAVE0_REGION = 4'h0;
  localparam logic [SLAVE_SEL_BITS-1:0] SLAVE1_REGION = 4'h1;
  localparam logic [SLAVE_SEL_BITS-1:0] SLAVE2_REGION = 4'h2;

  // Master codes carried in the upper ID nibble
  localparam int MASTER_CODE_BITS = AXI_IDS_BITS - AXI_ID_BITS;

  localparam logic [MASTER_CODE_BITS-1:0] MASTER0_CODE = 4'h0;
  localparam logic [MASTER_CODE_BITS-1:0] MASTER1_CODE = 4'h1;
  localparam logic [MASTER_CODE_BITS-1:0] MASTER2_CODE = 4'h2;

  // Outstanding write responses
  localparam int PEND_CNT_BITS = 3;

  typedef logic [PEND_CNT_BITS-1:0] pend_cnt_t;

  typedef enum logic [1:0] {
    AXI_MASTER_0_ID,
    AXI_MASTER_1_ID,
    AXI_MASTER_2_ID,
    AXI_MASTER_U_ID
  } axi_master_id_t;

  typedef enum logic [1:0] {
    LOCK_NO,
    LOCK_S0,
    LOCK_S1,
    LOCK_S2
  } data_arb_lock_t;

  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_DATA
  } route_state_t;

  typedef enum logic [1:0] {
    SEL_S0 = 2'd0,
    SEL_S1 = 2'd1,
    SEL_S2 = 2'd2
  } slave_sel_t;

  typedef struct packed {
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_ADDR_BITS-1:0] addr;
    logic [AXI_LEN_BITS-1:0]  len;
  } aw_req_t;

  typedef struct packed {
    logic [AXI_IDS_BITS-1:0]  id;
    logic [AXI_ADDR_BITS-1:0] addr;
    logic [AXI_LEN_BITS-1:0]  len;
  } aw_req_s_t;

  typedef struct packed {
    logic [AXI_DATA_BITS-1:0] data;
    logic [AXI_STRB_BITS-1:0] strb;
    logic                     last;
  } w_beat_t;

  typedef struct packed {
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_RESP_BITS-1:0] resp;
  } b_resp_t;

  typedef struct packed {
    logic [AXI_IDS_BITS-1:0]  id;
    logic [AXI_RESP_BITS-1:0] resp;
  } b_resp_s_t;

  // Owner of a slave-side ID
  function automatic axi_master_id_t data_decoder(input logic [AXI_IDS_BITS-1:0] id);
    axi_master_id_t master;
    case (id[AXI_IDS_BITS-1 -: MASTER_CODE_BITS])
      MASTER0_CODE: master = AXI_MASTER_0_ID;
      MASTER1_CODE: master = AXI_MASTER_1_ID;
      MASTER2_CODE: master = AXI_MASTER_2_ID;
      default:      master = AXI_MASTER_U_ID;
    endcase
    return master;
  endfunction

endpackage

`default_nettype wire
